//--- mpls_router_pkg.sv
/* MPLS router ingress definitions */

package mpls_router_pkg;

    ////////////////////////////////////////////////////////////////////////
    // Converged bus

    localparam int CONV_BYTES = 8;
    localparam int CONV_WIDTH = CONV_BYTES * 8;

    ////////////////////////////////////////////////////////////////////////
    // Physical ports

    localparam int NUM_8B_PORTS  = 2;
    localparam int NUM_32B_PORTS = 2;
    localparam int NUM_PORTS     = NUM_8B_PORTS + NUM_32B_PORTS;

    // Bytes per beat of each port class
    localparam int P8_BYTES  = 1;
    localparam int P32_BYTES = 4;

    // Arbiter index map, 8-bit ports first
    localparam int P8_BASE  = 0;
    localparam int P32_BASE = P8_BASE + NUM_8B_PORTS;

    // Port index carried in tuser
    localparam int PORT_IDX_WIDTH = $clog2(NUM_PORTS);

    ////////////////////////////////////////////////////////////////////////
    // Packet buffer

    // Depth in converged words, power of two
    localparam int BUF_DEPTH      = 16;
    localparam int BUF_ADDR_WIDTH = $clog2(BUF_DEPTH);
    // Extra bit tells full from empty
    localparam int BUF_PTR_WIDTH  = BUF_ADDR_WIDTH + 1;

    ////////////////////////////////////////////////////////////////////////
    // Arbiter

    typedef enum logic {
        ARB_IDLE,
        ARB_BURST
    } arb_state_t;

endpackage

//--- ing_width_adapt.sv
/* Narrow port width adapter */

`timescale 1ns/100ps

module ing_width_adapt
    import mpls_router_pkg::*;
#(
    parameter int IN_BYTES = 1
) (
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    in_tvalid,
    input  logic [IN_BYTES*8-1:0]   in_tdata,
    input  logic                    in_tlast,

    output logic                    word_valid,
    output logic [CONV_WIDTH-1:0]   word_data,
    output logic [CONV_BYTES-1:0]   word_keep,
    output logic                    word_last
);

    localparam int IN_WIDTH = IN_BYTES * 8;
    localparam int LANES    = CONV_BYTES / IN_BYTES;
    localparam int LANE_W   = (LANES > 1) ? $clog2(LANES) : 1;

    logic [LANE_W-1:0]      lane;
    logic [CONV_WIDTH-1:0]  asm_data;
    logic [CONV_WIDTH-1:0]  next_data;
    logic [CONV_BYTES-1:0]  next_keep;
    logic                   word_done;

    ////////////////////////////////////////////////////////////////////////
    // Assembly

    // Lane 0 starts a fresh word so unused bytes read as zero
    always_comb begin
        next_data = (lane == '0) ? '0 : asm_data;
        next_data[lane*IN_WIDTH +: IN_WIDTH] = in_tdata;
        for (int b = 0; b < CONV_BYTES; b++) begin
            next_keep[b] = (b < (int'(lane) + 1) * IN_BYTES);
        end
    end

    // Word closes when the last lane fills or the packet ends
    assign word_done = in_tvalid && (in_tlast || lane == LANE_W'(LANES - 1));

    ////////////////////////////////////////////////////////////////////////
    // Registers

    always_ff @(posedge clk) begin
        if (reset) begin
            lane       <= '0;
            word_valid <= 1'b0;
        end else begin
            word_valid <= word_done;
            if (in_tvalid) begin
                lane <= word_done ? '0 : lane + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_tvalid) begin
            asm_data <= next_data;
        end
        if (word_done) begin
            word_data <= next_data;
            word_keep <= next_keep;
            word_last <= in_tlast;
        end
    end

endmodule

//--- ing_port_buffer.sv
/* Per-port packet buffer */

`timescale 1ns/100ps

module ing_port_buffer
    import mpls_router_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    word_valid,
    input  logic [CONV_WIDTH-1:0]   word_data,
    input  logic [CONV_BYTES-1:0]   word_keep,
    input  logic                    word_last,

    output logic                    rd_valid,
    output logic [CONV_WIDTH-1:0]   rd_data,
    output logic [CONV_BYTES-1:0]   rd_keep,
    output logic                    rd_last,
    input  logic                    rd_ready,

    output logic                    overflow
);

    logic [CONV_WIDTH-1:0]      mem_data [BUF_DEPTH];
    logic [CONV_BYTES-1:0]      mem_keep [BUF_DEPTH];
    logic                       mem_last [BUF_DEPTH];

    // Tentative write, commit point and read pointers
    logic [BUF_PTR_WIDTH-1:0]   wr_ptr;
    logic [BUF_PTR_WIDTH-1:0]   commit_ptr;
    logic [BUF_PTR_WIDTH-1:0]   rd_ptr;

    // Whole packets waiting to be read
    logic [BUF_PTR_WIDTH-1:0]   pkt_cnt;

    logic                       dropping;
    logic [BUF_PTR_WIDTH-1:0]   used;
    logic                       full;
    logic                       wr_en;
    logic                       commit;
    logic                       rd_fire;
    logic                       rd_done;

    ////////////////////////////////////////////////////////////////////////
    // Status

    // Uncommitted words of the current packet count as used
    assign used    = wr_ptr - rd_ptr;
    assign full    = (used == BUF_PTR_WIDTH'(BUF_DEPTH));
    assign wr_en   = word_valid && !dropping && !full;
    assign commit  = wr_en && word_last;
    assign rd_fire = rd_valid && rd_ready;
    assign rd_done = rd_fire && rd_last;

    ////////////////////////////////////////////////////////////////////////
    // Storage

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_data[wr_ptr[BUF_ADDR_WIDTH-1:0]] <= word_data;
            mem_keep[wr_ptr[BUF_ADDR_WIDTH-1:0]] <= word_keep;
            mem_last[wr_ptr[BUF_ADDR_WIDTH-1:0]] <= word_last;
        end
    end

    assign rd_valid = (pkt_cnt != '0);
    assign rd_data  = mem_data[rd_ptr[BUF_ADDR_WIDTH-1:0]];
    assign rd_keep  = mem_keep[rd_ptr[BUF_ADDR_WIDTH-1:0]];
    assign rd_last  = mem_last[rd_ptr[BUF_ADDR_WIDTH-1:0]];

    ////////////////////////////////////////////////////////////////////////
    // Write side with drop handling

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr     <= '0;
            commit_ptr <= '0;
            dropping   <= 1'b0;
            overflow   <= 1'b0;
        end else begin
            overflow <= 1'b0;
            if (word_valid) begin
                if (dropping) begin
                    // Discard the tail of a dropped packet
                    if (word_last) begin
                        dropping <= 1'b0;
                    end
                end else if (full) begin
                    // No room, rewind to the last whole packet
                    wr_ptr   <= commit_ptr;
                    overflow <= 1'b1;
                    dropping <= !word_last;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                    if (word_last) begin
                        commit_ptr <= wr_ptr + 1'b1;
                    end
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Read side and packet count

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr  <= '0;
            pkt_cnt <= '0;
        end else begin
            if (rd_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({commit, rd_done})
                2'b10:   pkt_cnt <= pkt_cnt + 1'b1;
                2'b01:   pkt_cnt <= pkt_cnt - 1'b1;
                default: pkt_cnt <= pkt_cnt;
            endcase
        end
    end

endmodule

//--- ing_arb_mux.sv
/* Round-robin packet arbiter */

`timescale 1ns/100ps

module ing_arb_mux
    import mpls_router_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,

    input  logic [NUM_PORTS-1:0]        rd_valid,
    input  logic [CONV_WIDTH-1:0]       rd_data [NUM_PORTS],
    input  logic [CONV_BYTES-1:0]       rd_keep [NUM_PORTS],
    input  logic [NUM_PORTS-1:0]        rd_last,
    output logic [NUM_PORTS-1:0]        rd_ready,

    output logic                        out_tvalid,
    output logic [CONV_WIDTH-1:0]       out_tdata,
    output logic [CONV_BYTES-1:0]       out_tkeep,
    output logic                        out_tlast,
    output logic [PORT_IDX_WIDTH-1:0]   out_tuser,
    input  logic                        out_tready
);

    arb_state_t                     state;
    logic [PORT_IDX_WIDTH-1:0]      grant;
    logic [PORT_IDX_WIDTH-1:0]      last_grant;
    logic [PORT_IDX_WIDTH-1:0]      pick;
    logic                           pick_valid;
    logic                           last_accept;

    ////////////////////////////////////////////////////////////////////////
    // Round-robin search

    // First ready port after the previous winner, wrapping around
    always_comb begin
        int idx;
        pick_valid = 1'b0;
        pick       = '0;
        for (int i = 1; i <= NUM_PORTS; i++) begin
            idx = (int'(last_grant) + i) % NUM_PORTS;
            if (!pick_valid && rd_valid[idx]) begin
                pick_valid = 1'b1;
                pick       = PORT_IDX_WIDTH'(idx);
            end
        end
    end

    assign last_accept = out_tvalid && out_tready && out_tlast;

    ////////////////////////////////////////////////////////////////////////
    // Grant FSM

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= ARB_IDLE;
            grant      <= '0;
            // Search begins at port 0
            last_grant <= PORT_IDX_WIDTH'(NUM_PORTS - 1);
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (pick_valid) begin
                        grant <= pick;
                        state <= ARB_BURST;
                    end
                end
                ARB_BURST: begin
                    // Hold the grant until the packet's last word leaves
                    if (last_accept) begin
                        last_grant <= grant;
                        state      <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Output mux

    assign out_tvalid = (state == ARB_BURST) && rd_valid[grant];
    assign out_tdata  = rd_data[grant];
    assign out_tkeep  = rd_keep[grant];
    assign out_tlast  = rd_last[grant];
    assign out_tuser  = grant;

    // Back-pressure reaches the granted buffer only
    always_comb begin
        rd_ready = '0;
        if (state == ARB_BURST) begin
            rd_ready[grant] = out_tready;
        end
    end

endmodule

//--- mpls_ingress.sv
/* MPLS router ingress datapath */

`timescale 1ns/100ps

module mpls_ingress
    import mpls_router_pkg::*;
(
    input  logic                                    clk,
    input  logic                                    reset,

    input  logic [NUM_8B_PORTS-1:0]                 p8_tvalid,
    input  logic [NUM_8B_PORTS-1:0][P8_BYTES*8-1:0] p8_tdata,
    input  logic [NUM_8B_PORTS-1:0]                 p8_tlast,

    input  logic [NUM_32B_PORTS-1:0]                p32_tvalid,
    input  logic [NUM_32B_PORTS-1:0][P32_BYTES*8-1:0] p32_tdata,
    input  logic [NUM_32B_PORTS-1:0]                p32_tlast,

    output logic                                    out_tvalid,
    output logic [CONV_WIDTH-1:0]                   out_tdata,
    output logic [CONV_BYTES-1:0]                   out_tkeep,
    output logic                                    out_tlast,
    output logic [PORT_IDX_WIDTH-1:0]               out_tuser,
    input  logic                                    out_tready,

    output logic [NUM_PORTS-1:0]                    overflow
);

    // Adapter to buffer, indexed by arbiter port
    logic [NUM_PORTS-1:0]       word_valid;
    logic [CONV_WIDTH-1:0]      word_data [NUM_PORTS];
    logic [CONV_BYTES-1:0]      word_keep [NUM_PORTS];
    logic [NUM_PORTS-1:0]       word_last;

    // Buffer to arbiter
    logic [NUM_PORTS-1:0]       rd_valid;
    logic [CONV_WIDTH-1:0]      rd_data [NUM_PORTS];
    logic [CONV_BYTES-1:0]      rd_keep [NUM_PORTS];
    logic [NUM_PORTS-1:0]       rd_last;
    logic [NUM_PORTS-1:0]       rd_ready;

    ////////////////////////////////////////////////////////////////////////
    // Width adapters

    for (genvar i = 0; i < NUM_8B_PORTS; i++) begin : g_adapt_8b
        ing_width_adapt #(
            .IN_BYTES   ( P8_BYTES                  )
        ) u_adapt (
            .clk        ( clk                       ),
            .reset      ( reset                     ),
            .in_tvalid  ( p8_tvalid[i]              ),
            .in_tdata   ( p8_tdata[i]               ),
            .in_tlast   ( p8_tlast[i]               ),
            .word_valid ( word_valid[P8_BASE+i]     ),
            .word_data  ( word_data[P8_BASE+i]      ),
            .word_keep  ( word_keep[P8_BASE+i]      ),
            .word_last  ( word_last[P8_BASE+i]      )
        );
    end

    for (genvar i = 0; i < NUM_32B_PORTS; i++) begin : g_adapt_32b
        ing_width_adapt #(
            .IN_BYTES   ( P32_BYTES                 )
        ) u_adapt (
            .clk        ( clk                       ),
            .reset      ( reset                     ),
            .in_tvalid  ( p32_tvalid[i]             ),
            .in_tdata   ( p32_tdata[i]              ),
            .in_tlast   ( p32_tlast[i]              ),
            .word_valid ( word_valid[P32_BASE+i]    ),
            .word_data  ( word_data[P32_BASE+i]     ),
            .word_keep  ( word_keep[P32_BASE+i]     ),
            .word_last  ( word_last[P32_BASE+i]     )
        );
    end

    ////////////////////////////////////////////////////////////////////////
    // Packet buffers

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_buf
        ing_port_buffer u_buf (
            .clk        ( clk           ),
            .reset      ( reset         ),
            .word_valid ( word_valid[p] ),
            .word_data  ( word_data[p]  ),
            .word_keep  ( word_keep[p]  ),
            .word_last  ( word_last[p]  ),
            .rd_valid   ( rd_valid[p]   ),
            .rd_data    ( rd_data[p]    ),
            .rd_keep    ( rd_keep[p]    ),
            .rd_last    ( rd_last[p]    ),
            .rd_ready   ( rd_ready[p]   ),
            .overflow   ( overflow[p]   )
        );
    end

    ////////////////////////////////////////////////////////////////////////
    // Merge onto the converged bus

    ing_arb_mux u_arb (
        .clk        ( clk           ),
        .reset      ( reset         ),
        .rd_valid   ( rd_valid      ),
        .rd_data    ( rd_data       ),
        .rd_keep    ( rd_keep       ),
        .rd_last    ( rd_last       ),
        .rd_ready   ( rd_ready      ),
        .out_tvalid ( out_tvalid    ),
        .out_tdata  ( out_tdata     ),
        .out_tkeep  ( out_tkeep     ),
        .out_tlast  ( out_tlast     ),
        .out_tuser  ( out_tuser     ),
        .out_tready ( out_tready    )
    );

endmodule

//--- mpls_ingress_chk.sv
/* Output stream assertions */

`timescale 1ns/100ps

module mpls_ingress_chk
    import mpls_router_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        out_tvalid,
    input  logic [CONV_WIDTH-1:0]       out_tdata,
    input  logic [CONV_BYTES-1:0]       out_tkeep,
    input  logic                        out_tlast,
    input  logic [PORT_IDX_WIDTH-1:0]   out_tuser,
    input  logic                        out_tready,
    input  logic [NUM_PORTS-1:0]        overflow
);

    // Failed assertion count
    int fail_count = 0;

    // Nothing valid and no drop flags right after reset
    a_reset_clear: assert property (@(posedge clk)
        reset |=> (!out_tvalid && overflow == '0))
        else begin
            fail_count++;
            $error("out_tvalid or overflow high in the cycle after reset");
        end

    // Stalled word holds until accepted
    a_stall_hold: assert property (@(posedge clk) disable iff (reset)
        (out_tvalid && !out_tready) |=> (out_tvalid && $stable(out_tdata)
            && $stable(out_tkeep) && $stable(out_tlast) && $stable(out_tuser)))
        else begin
            fail_count++;
            $error("output stream changed while stalled");
        end

endmodule

//--- ing_scoreboard.sv
/* Ingress output scoreboard */

`timescale 1ns/100ps

module ing_scoreboard
    import mpls_router_pkg::*;
(
    input  logic                                        clk,
    input  logic                                        reset,

    input  logic [NUM_8B_PORTS-1:0]                     p8_tvalid,
    input  logic [NUM_8B_PORTS-1:0][P8_BYTES*8-1:0]     p8_tdata,
    input  logic [NUM_8B_PORTS-1:0]                     p8_tlast,
    input  logic [NUM_32B_PORTS-1:0]                    p32_tvalid,
    input  logic [NUM_32B_PORTS-1:0][P32_BYTES*8-1:0]   p32_tdata,
    input  logic [NUM_32B_PORTS-1:0]                    p32_tlast,

    input  logic                                        out_tvalid,
    input  logic [CONV_WIDTH-1:0]                       out_tdata,
    input  logic [CONV_BYTES-1:0]                       out_tkeep,
    input  logic                                        out_tlast,
    input  logic [PORT_IDX_WIDTH-1:0]                   out_tuser,
    input  logic                                        out_tready,
    input  logic [NUM_PORTS-1:0]                        overflow,

    input  logic [1:0]                                  phase,
    input  logic                                        rr_check,
    input  logic                                        done
);

    // Bytes of the packet currently arriving on each port
    logic [7:0]             cur_bytes [NUM_PORTS][$];

    // Expected output words per port
    logic [CONV_WIDTH-1:0]  exp_data [NUM_PORTS][$];
    logic [CONV_BYTES-1:0]  exp_keep [NUM_PORTS][$];
    logic                   exp_last [NUM_PORTS][$];

    int                     occupancy [NUM_PORTS];
    int                     drops_expected [NUM_PORTS];
    int                     drops_seen [NUM_PORTS];
    int                     error_count = 0;
    int                     pending_words = 0;
    int                     pkts_in = 0;
    int                     pkts_out = 0;
    logic                   in_packet = 1'b0;
    logic                   final_done = 1'b0;
    logic [PORT_IDX_WIDTH-1:0] cur_port = '0;
    logic [PORT_IDX_WIDTH-1:0] rr_next = '0;

    initial begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            occupancy[p]      = 0;
            drops_expected[p] = 0;
            drops_seen[p]     = 0;
        end
    end

    function automatic string phase_name(input logic [1:0] ph);
        case (ph)
            2'd0:    return "fill";
            2'd1:    return "overflow";
            2'd2:    return "random";
            default: return "idle";
        endcase
    endfunction

    function automatic logic [CONV_WIDTH-1:0] byte_mask(input logic [CONV_BYTES-1:0] keep);
        logic [CONV_WIDTH-1:0] mask;
        for (int b = 0; b < CONV_BYTES; b++) begin
            mask[b*8 +: 8] = {8{keep[b]}};
        end
        return mask;
    endfunction

    task automatic report_mismatch(input string check, input int p,
                                   input logic [CONV_WIDTH-1:0] expected,
                                   input logic [CONV_WIDTH-1:0] actual);
        error_count++;
        $display("FAILED %s/%s port %0d: expected %h, actual %h",
                 phase_name(phase), check, p, expected, actual);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reference model

    // Low byte first, a new word every CONV_BYTES bytes, keep marks filled lanes
    task automatic pack_packet(input int p);
        int n;
        int words;
        logic [CONV_WIDTH-1:0] data;
        logic [CONV_BYTES-1:0] keep;
        n = cur_bytes[p].size();
        words = (n + CONV_BYTES - 1) / CONV_BYTES;
        if (occupancy[p] + words > BUF_DEPTH) begin
            drops_expected[p]++;
        end else begin
            for (int w = 0; w < words; w++) begin
                data = '0;
                keep = '0;
                for (int b = 0; b < CONV_BYTES; b++) begin
                    if (w * CONV_BYTES + b < n) begin
                        data[b*8 +: 8] = cur_bytes[p][w*CONV_BYTES+b];
                        keep[b] = 1'b1;
                    end
                end
                exp_data[p].push_back(data);
                exp_keep[p].push_back(keep);
                exp_last[p].push_back(w == words - 1);
            end
            occupancy[p]  += words;
            pending_words += words;
            pkts_in++;
        end
        cur_bytes[p].delete();
    endtask

    task automatic capture_inputs();
        for (int i = 0; i < NUM_8B_PORTS; i++) begin
            if (p8_tvalid[i]) begin
                cur_bytes[P8_BASE+i].push_back(p8_tdata[i]);
                if (p8_tlast[i]) begin
                    pack_packet(P8_BASE + i);
                end
            end
        end
        for (int i = 0; i < NUM_32B_PORTS; i++) begin
            if (p32_tvalid[i]) begin
                for (int b = 0; b < P32_BYTES; b++) begin
                    cur_bytes[P32_BASE+i].push_back(p32_tdata[i][b*8 +: 8]);
                end
                if (p32_tlast[i]) begin
                    pack_packet(P32_BASE + i);
                end
            end
        end
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (overflow[p]) begin
                drops_seen[p]++;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Output comparison

    task automatic check_output();
        int p;
        logic [CONV_WIDTH-1:0] mask;
        logic [CONV_WIDTH-1:0] d;
        logic [CONV_BYTES-1:0] k;
        logic l;
        p = int'(out_tuser);
        // A started packet must finish before another port shows up
        if (in_packet && out_tuser != cur_port) begin
            report_mismatch("interleave tuser", p, CONV_WIDTH'(cur_port), CONV_WIDTH'(out_tuser));
        end
        if (!in_packet && rr_check) begin
            if (out_tuser != rr_next) begin
                report_mismatch("round robin", p, CONV_WIDTH'(rr_next), CONV_WIDTH'(out_tuser));
            end
            rr_next = rr_next + 1'b1;
        end
        if (exp_data[p].size() == 0) begin
            error_count++;
            $display("ERROR: output word on port %0d with no packet expected", p);
        end else begin
            d = exp_data[p].pop_front();
            k = exp_keep[p].pop_front();
            l = exp_last[p].pop_front();
            occupancy[p]--;
            pending_words--;
            mask = byte_mask(k);
            if ((out_tdata & mask) != d) begin
                report_mismatch("data", p, d, out_tdata & mask);
            end
            if (out_tkeep != k) begin
                report_mismatch("keep", p, CONV_WIDTH'(k), CONV_WIDTH'(out_tkeep));
            end
            if (out_tlast != l) begin
                report_mismatch("last", p, CONV_WIDTH'(l), CONV_WIDTH'(out_tlast));
            end
        end
        in_packet = !out_tlast;
        cur_port  = out_tuser;
        if (out_tlast) begin
            pkts_out++;
        end
    endtask

    task automatic final_checks();
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (exp_data[p].size() != 0) begin
                error_count++;
                $display("ERROR: %0d expected words never left port %0d",
                         exp_data[p].size(), p);
            end
            if (drops_seen[p] != drops_expected[p]) begin
                report_mismatch("overflow pulses", p, CONV_WIDTH'(drops_expected[p]),
                                CONV_WIDTH'(drops_seen[p]));
            end
        end
    endtask

    task automatic print_summary();
        int dropped;
        dropped = 0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            dropped += drops_seen[p];
        end
        $display("Scoreboard: %0d errors, %0d packets expected, %0d received, %0d dropped",
                 error_count, pkts_in, pkts_out, dropped);
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            capture_inputs();
            if (out_tvalid && out_tready) begin
                check_output();
            end
            if (done && !final_done) begin
                final_checks();
                print_summary();
                final_done = 1'b1;
            end
        end
    end

endmodule

//--- tb_mpls_ingress.sv
/* MPLS ingress testbench */

`timescale 1ns/100ps

module tb_mpls_ingress
    import mpls_router_pkg::*;
();

    localparam int CLK_PERIOD      = 8;
    localparam int MAX_PKT_BYTES   = 48;
    localparam int OVF_PKTS        = 5;
    localparam int OVF_PKT_BYTES   = 40;
    localparam int RANDOM_PKTS     = 40;
    localparam int TOTAL_PKTS      = NUM_PORTS + OVF_PKTS + RANDOM_PKTS;
    // Worst case beats per packet plus gap, doubled, plus a margin
    localparam int TIMEOUT_NS      = TOTAL_PKTS * (MAX_PKT_BYTES + 8) * CLK_PERIOD * 2 + 2000;

    logic                                       clk = 1'b0;
    logic                                       reset;
    logic [NUM_8B_PORTS-1:0]                    p8_tvalid;
    logic [NUM_8B_PORTS-1:0][P8_BYTES*8-1:0]    p8_tdata;
    logic [NUM_8B_PORTS-1:0]                    p8_tlast;
    logic [NUM_32B_PORTS-1:0]                   p32_tvalid;
    logic [NUM_32B_PORTS-1:0][P32_BYTES*8-1:0]  p32_tdata;
    logic [NUM_32B_PORTS-1:0]                   p32_tlast;
    logic                                       out_tvalid;
    logic [CONV_WIDTH-1:0]                      out_tdata;
    logic [CONV_BYTES-1:0]                      out_tkeep;
    logic                                       out_tlast;
    logic [PORT_IDX_WIDTH-1:0]                  out_tuser;
    logic                                       out_tready;
    logic [NUM_PORTS-1:0]                       overflow;

    logic [1:0]                                 phase;
    logic                                       rr_check;
    logic                                       done;
    logic                                       rand_ready;
    int                                         seed;

    always #(CLK_PERIOD / 2) clk = ~clk;

    mpls_ingress u_mpls_ingress (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .p8_tvalid  ( p8_tvalid  ),
        .p8_tdata   ( p8_tdata   ),
        .p8_tlast   ( p8_tlast   ),
        .p32_tvalid ( p32_tvalid ),
        .p32_tdata  ( p32_tdata  ),
        .p32_tlast  ( p32_tlast  ),
        .out_tvalid ( out_tvalid ),
        .out_tdata  ( out_tdata  ),
        .out_tkeep  ( out_tkeep  ),
        .out_tlast  ( out_tlast  ),
        .out_tuser  ( out_tuser  ),
        .out_tready ( out_tready ),
        .overflow   ( overflow   )
    );

    ing_scoreboard u_scoreboard (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .p8_tvalid  ( p8_tvalid  ),
        .p8_tdata   ( p8_tdata   ),
        .p8_tlast   ( p8_tlast   ),
        .p32_tvalid ( p32_tvalid ),
        .p32_tdata  ( p32_tdata  ),
        .p32_tlast  ( p32_tlast  ),
        .out_tvalid ( out_tvalid ),
        .out_tdata  ( out_tdata  ),
        .out_tkeep  ( out_tkeep  ),
        .out_tlast  ( out_tlast  ),
        .out_tuser  ( out_tuser  ),
        .out_tready ( out_tready ),
        .overflow   ( overflow   ),
        .phase      ( phase      ),
        .rr_check   ( rr_check   ),
        .done       ( done       )
    );

    bind mpls_ingress mpls_ingress_chk u_chk (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .out_tvalid ( out_tvalid ),
        .out_tdata  ( out_tdata  ),
        .out_tkeep  ( out_tkeep  ),
        .out_tlast  ( out_tlast  ),
        .out_tuser  ( out_tuser  ),
        .out_tready ( out_tready ),
        .overflow   ( overflow   )
    );

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers

    // Advance one clock, redrawing out_tready when random back-pressure is on
    task automatic next_cycle();
        @(posedge clk);
        if (rand_ready) begin
            out_tready <= (($random(seed) & 3) != 0);
        end
    endtask

    // 32-bit ports round the length up to whole beats
    task automatic send_packet(input int port, input int nbytes);
        int bpb;
        int beats;
        bpb   = (port < P32_BASE) ? P8_BYTES : P32_BYTES;
        beats = (nbytes + bpb - 1) / bpb;
        for (int i = 0; i < beats; i++) begin
            if (port < P32_BASE) begin
                p8_tvalid[port-P8_BASE] <= 1'b1;
                p8_tdata[port-P8_BASE]  <= 8'($random(seed));
                p8_tlast[port-P8_BASE]  <= (i == beats - 1);
            end else begin
                p32_tvalid[port-P32_BASE] <= 1'b1;
                p32_tdata[port-P32_BASE]  <= 32'($random(seed));
                p32_tlast[port-P32_BASE]  <= (i == beats - 1);
            end
            next_cycle();
        end
        p8_tvalid  <= '0;
        p8_tlast   <= '0;
        p32_tvalid <= '0;
        p32_tlast  <= '0;
    endtask

    task automatic wait_drain();
        next_cycle();
        while (u_scoreboard.pending_words != 0) begin
            next_cycle();
        end
        repeat (4) next_cycle();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        int port;
        int len;
        seed       = 32'h0153493b;
        reset      = 1'b1;
        p8_tvalid  = '0;
        p8_tdata   = '0;
        p8_tlast   = '0;
        p32_tvalid = '0;
        p32_tdata  = '0;
        p32_tlast  = '0;
        out_tready = 1'b0;
        phase      = 2'd0;
        rr_check   = 1'b0;
        done       = 1'b0;
        rand_ready = 1'b0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        next_cycle();

        // Fill all buffers under stall, then release in port order
        send_packet(0, 13);
        send_packet(1, 8);
        send_packet(2, 20);
        send_packet(3, 36);
        repeat (4) next_cycle();
        rr_check   <= 1'b1;
        out_tready <= 1'b1;
        wait_drain();
        rr_check   <= 1'b0;

        // Five 5-word packets into a 16-word buffer
        phase      <= 2'd1;
        out_tready <= 1'b0;
        for (int k = 0; k < OVF_PKTS; k++) begin
            send_packet(0, OVF_PKT_BYTES);
        end
        repeat (4) next_cycle();
        out_tready <= 1'b1;
        wait_drain();

        phase      <= 2'd2;
        rand_ready = 1'b1;
        for (int k = 0; k < RANDOM_PKTS; k++) begin
            port = $unsigned($random(seed)) % NUM_PORTS;
            len  = 1 + $unsigned($random(seed)) % MAX_PKT_BYTES;
            send_packet(port, len);
            repeat ($unsigned($random(seed)) % 4) next_cycle();
        end
        rand_ready = 1'b0;
        out_tready <= 1'b1;
        wait_drain();

        done <= 1'b1;
        repeat (2) next_cycle();
        if (u_scoreboard.error_count == 0 && u_mpls_ingress.u_chk.fail_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: run did not finish within %0d ns", TIMEOUT_NS);
        u_scoreboard.print_summary();
        $display("Test FAILED");
        $finish;
    end

endmodule

//--- flist.f
mpls_router_pkg.sv
ing_width_adapt.sv
ing_port_buffer.sv
ing_arb_mux.sv
mpls_ingress.sv
mpls_ingress_chk.sv
ing_scoreboard.sv
tb_mpls_ingress.sv

//--- run.sh
#!/bin/sh
# Build and run the ingress testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mpls_ingress \
    -f flist.f \
    -o sim_mpls_ingress

./obj_dir/sim_mpls_ingress | tee sim.log

# Pass only when the testbench printed its pass line
grep -q "^Test OK$" sim.log
